/* common/igr_defines.svh */
// Ingress switch sizing macros shared by every pipeline stage
`ifndef IGR_DEFINES_SVH
`define IGR_DEFINES_SVH

// =========================================================================
// Ports and datapath
// =========================================================================
// Ports sharing the segment stream, also the destination mask width
`define IGR_NUM_PORTS 5
// Enough bits to number every port
`define IGR_PORT_W 3
// One segment word
`define IGR_DATA_W 64

// =========================================================================
// Forwarding table
// =========================================================================
`define IGR_FWD_DEPTH 16
// Table index, taken from the low bits of the destination MAC
`define IGR_FWD_AW 4

// =========================================================================
// Segment buffer and frame length
// =========================================================================
`define IGR_PTR_W 8
// Length in words
`define IGR_LEN_W 8

// Destination MAC in the sop word, first octet in the top byte
`define IGR_DMAC_MSB 63
`define IGR_DMAC_LSB 16
// Group bit, lowest bit of the first octet
`define IGR_DMAC_GROUP 56

`endif

/* common/igr_frame_pkg.sv */
// Frame classification and end-of-frame tag types for ingress traffic
`include "igr_defines.svh"

package igr_frame_pkg;

  // =======================================================================
  // Frame kind
  // =======================================================================
  // Resolved once from the sop word, held for the whole frame
  typedef enum logic [1:0] {
    // Plain station address, forwarding table lookup
    KIND_UCAST = 2'd0,
    // Group bit set, flooded
    KIND_MCAST = 2'd1,
    // All-ones destination, flooded
    KIND_BCAST = 2'd2,
    // Sop and eop on one word, dropped with empty mask
    KIND_RUNT  = 2'd3
  } frame_kind_e;

  // =======================================================================
  // End-of-frame tag
  // =======================================================================
  // One per frame, issued with the buffer write of the eop word
  typedef struct packed {
    frame_kind_e                kind;
    // Egress ports, source port always cleared
    logic [`IGR_NUM_PORTS-1:0]  dst_mask;
    logic [`IGR_PORT_W-1:0]     src_port;
    // Words in the frame, never zero
    logic [`IGR_LEN_W-1:0]      len;
    // Buffer pointer of the first word
    logic [`IGR_PTR_W-1:0]      ptr;
  } igr_tag_t;

endpackage

/* common/igr_fwd_pkg.sv */
// Forwarding table entry and configuration opcode types
`include "igr_defines.svh"

package igr_fwd_pkg;

  // =======================================================================
  // Configuration
  // =======================================================================
  // Opcode carried with each cfg_wr pulse
  typedef enum logic [0:0] {
    // Install valid entry with the given mask
    CFG_SET   = 1'b0,
    // Invalidate the entry, later lookups miss
    CFG_CLEAR = 1'b1
  } cfg_op_e;

  // =======================================================================
  // Table entry
  // =======================================================================
  typedef struct packed {
    logic                      valid;
    // Egress ports for a unicast hit
    logic [`IGR_NUM_PORTS-1:0] port_mask;
  } fwd_entry_t;

endpackage

/* common/igr_seg_if.sv */
// Segment bus carrying words and frame attributes between ingress stages
`timescale 1ns/100ps
`include "igr_defines.svh"

interface igr_seg_if import igr_frame_pkg::*; ();

  // Word strobes
  logic                      valid;
  logic                      sop;
  logic                      eop;
  // Source port of the word
  logic [`IGR_PORT_W-1:0]    port;
  logic [`IGR_DATA_W-1:0]    data;
  // Frame attributes, constant from sop to eop
  frame_kind_e               kind;
  // Only carried from execute onward
  logic [`IGR_NUM_PORTS-1:0] dst_mask;

  // =======================================================================
  // Stage views
  // =======================================================================
  // Decode output, no mask yet
  modport decode_mp (
    output valid, sop, eop, port, data, kind
  );

  // Execute input from decode
  modport exec_mp (
    input valid, sop, eop, port, data, kind
  );

  // Execute output, adds the resolved mask
  modport exec_drv_mp (
    output valid, sop, eop, port, data, kind, dst_mask
  );

  // Result input
  modport result_mp (
    input valid, sop, eop, port, data, kind, dst_mask
  );

endinterface

/* dv/igr_tb.sv */
// Table-driven testbench for the ingress pipeline with a forwarding model and watchdog
`timescale 1ns/100ps
`include "igr_defines.svh"

module igr_tb import igr_frame_pkg::*, igr_fwd_pkg::*; ();

  localparam int NUM_TESTS = 10;
  localparam int CLK_HALF  = 50;
  // Input cycle to buffer write cycle
  localparam int PIPE_LAT  = 3;
  localparam int MARGIN    = 20;

  // One frame of stimulus with its expected classification
  typedef struct {
    string                     name;
    logic [`IGR_PORT_W-1:0]    port;
    logic [47:0]               dmac;
    int                        nwords;
    logic                      cfg_en;
    cfg_op_e                   cfg_op;
    logic [`IGR_FWD_AW-1:0]    cfg_addr;
    logic [`IGR_NUM_PORTS-1:0] cfg_mask;
    frame_kind_e               exp_kind;
    logic [`IGR_NUM_PORTS-1:0] exp_mask;
  } frame_rec_t;

  typedef struct {
    int                     test;
    logic [`IGR_PTR_W-1:0]  ptr;
    logic [`IGR_DATA_W-1:0] data;
    logic                   eop;
    int                     drive_cyc;
  } word_exp_t;

  typedef struct {
    int                        test;
    frame_kind_e               kind;
    logic [`IGR_NUM_PORTS-1:0] mask;
    logic [`IGR_PORT_W-1:0]    src_port;
    logic [`IGR_LEN_W-1:0]     len;
    logic [`IGR_PTR_W-1:0]     ptr;
  } tag_exp_t;

  logic                      ingress_clock;
  logic                      rst_n;
  logic                      in_valid;
  logic                      in_sop;
  logic                      in_eop;
  logic [`IGR_PORT_W-1:0]    in_port;
  logic [`IGR_DATA_W-1:0]    in_data;
  logic                      cfg_wr;
  cfg_op_e                   cfg_op;
  logic [`IGR_FWD_AW-1:0]    cfg_addr;
  logic [`IGR_NUM_PORTS-1:0] cfg_mask;
  logic                      buf_wr_valid;
  logic [`IGR_PTR_W-1:0]     buf_wr_ptr;
  logic [`IGR_DATA_W-1:0]    buf_wr_data;
  logic                      tag_valid;
  frame_kind_e               tag_kind;
  logic [`IGR_NUM_PORTS-1:0] tag_dst_mask;
  logic [`IGR_PORT_W-1:0]    tag_src_port;
  logic [`IGR_LEN_W-1:0]     tag_len;
  logic [`IGR_PTR_W-1:0]     tag_ptr;

  frame_rec_t                tests [NUM_TESTS];
  int                        test_err [NUM_TESTS];
  word_exp_t                 word_q [$];
  tag_exp_t                  tag_q [$];
  // Forwarding model mirroring every config write
  logic                      model_valid [`IGR_FWD_DEPTH];
  logic [`IGR_NUM_PORTS-1:0] model_mask [`IGR_FWD_DEPTH];
  // Pointers count words from zero and wrap with their width
  logic [`IGR_PTR_W-1:0]     exp_ptr;
  logic [31:0]               lcg_state;
  int                        cyc = 0;
  int                        errors = 0;
  int                        checks = 0;
  int                        tags_seen = 0;

  igr_top u_dut (.*);

  // =========================================================================
  // Clock, cycle count, payload source
  // =========================================================================
  initial begin
    ingress_clock = 1'b0;
    forever #CLK_HALF ingress_clock = ~ingress_clock;
  end

  always @(posedge ingress_clock) cyc <= cyc + 1;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // =========================================================================
  // Reference rules and compare tasks
  // =========================================================================
  // Runt before all ones before group bit of the first octet
  function automatic frame_kind_e predict_kind(input int t);
    if (tests[t].nwords == 1) return KIND_RUNT;
    if (&tests[t].dmac) return KIND_BCAST;
    if (tests[t].dmac[40]) return KIND_MCAST;
    return KIND_UCAST;
  endfunction

  function automatic logic [`IGR_NUM_PORTS-1:0] predict_mask(input int t,
                                                             input frame_kind_e k);
    logic [`IGR_NUM_PORTS-1:0] m;
    logic [`IGR_FWD_AW-1:0]    idx;
    idx = tests[t].dmac[`IGR_FWD_AW-1:0];
    if (k == KIND_RUNT) m = '0;
    else if (k == KIND_UCAST && model_valid[idx]) m = model_mask[idx];
    else m = '1;
    return m & ~(`IGR_NUM_PORTS'(1) << tests[t].port);
  endfunction

  task automatic note_failure(input int t, input string msg);
    errors++;
    if (t >= 0) test_err[t]++;
    $display("ERROR: %s", msg);
  endtask

  task automatic check_kind(input int t, input frame_kind_e exp, input frame_kind_e act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_err[t]++;
      $display("MISMATCH %s kind: expected %s, actual %s", tests[t].name, exp.name(),
               act.name());
    end
  endtask

  task automatic check_mask(input int t, input logic [`IGR_NUM_PORTS-1:0] exp,
                            input logic [`IGR_NUM_PORTS-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_err[t]++;
      $display("MISMATCH %s dst_mask: expected %b, actual %b", tests[t].name, exp, act);
    end
  endtask

  // Length, pointer, source port and latency
  task automatic check_field(input int t, input string field, input logic [7:0] exp,
                             input logic [7:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_err[t]++;
      $display("MISMATCH %s %s: expected %0d, actual %0d", tests[t].name, field, exp, act);
    end
  endtask

  task automatic check_data(input int t, input logic [`IGR_DATA_W-1:0] exp,
                            input logic [`IGR_DATA_W-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_err[t]++;
      $display("MISMATCH %s data: expected %h, actual %h", tests[t].name, exp, act);
    end
  endtask

  // =========================================================================
  // Stimulus
  // =========================================================================
  task automatic load_tests();
    tests[0] = '{"ucast_hit", 3'd0, 48'h0200_0000_0003, 4, 1'b1, CFG_SET, 4'd3, 5'b00110,
                 KIND_UCAST, 5'b00110};
    tests[1] = '{"ucast_src_cut", 3'd1, 48'h0200_0000_0003, 3, 1'b0, CFG_SET, 4'd0, 5'b0,
                 KIND_UCAST, 5'b00100};
    tests[2] = '{"ucast_miss", 3'd2, 48'h0200_0000_0005, 5, 1'b0, CFG_SET, 4'd0, 5'b0,
                 KIND_UCAST, 5'b11011};
    tests[3] = '{"ucast_cleared", 3'd0, 48'h0200_0000_0003, 2, 1'b1, CFG_CLEAR, 4'd3, 5'b0,
                 KIND_UCAST, 5'b11110};
    // Valid entries at the group and broadcast indexes are ignored by flooding
    tests[4] = '{"bcast", 3'd3, 48'hFFFF_FFFF_FFFF, 3, 1'b1, CFG_SET, 4'd15, 5'b00001,
                 KIND_BCAST, 5'b10111};
    tests[5] = '{"mcast", 3'd4, 48'h0100_5E00_0001, 6, 1'b1, CFG_SET, 4'd1, 5'b00010,
                 KIND_MCAST, 5'b01111};
    tests[6] = '{"runt", 3'd2, 48'h0200_0000_0007, 1, 1'b0, CFG_SET, 4'd0, 5'b0,
                 KIND_RUNT, 5'b00000};
    // Long frame carries the pointer past 255
    tests[7] = '{"long_wrap", 3'd1, 48'h0200_0000_0009, 250, 1'b1, CFG_SET, 4'd9, 5'b11001,
                 KIND_UCAST, 5'b11001};
    tests[8] = '{"b2b_port4", 3'd4, 48'h0200_0000_0009, 2, 1'b0, CFG_SET, 4'd0, 5'b0,
                 KIND_UCAST, 5'b01001};
    tests[9] = '{"b2b_runt", 3'd3, 48'hFFFF_FFFF_FFFF, 1, 1'b0, CFG_SET, 4'd0, 5'b0,
                 KIND_RUNT, 5'b00000};
    for (int t = 0; t < NUM_TESTS; t++) test_err[t] = 0;
  endtask

  // Called on a falling edge and returns on the falling edge after the eop word
  task automatic drive_frame(input int t);
    logic [`IGR_DATA_W-1:0] word;
    logic [`IGR_PTR_W-1:0]  first_ptr;
    frame_kind_e            kind;
    first_ptr = exp_ptr;
    // Config rides with sop and lands before sop reaches execute
    cfg_wr   = tests[t].cfg_en;
    cfg_op   = tests[t].cfg_op;
    cfg_addr = tests[t].cfg_addr;
    cfg_mask = tests[t].cfg_mask;
    if (tests[t].cfg_en) begin
      model_valid[tests[t].cfg_addr] = (tests[t].cfg_op == CFG_SET);
      model_mask[tests[t].cfg_addr]  = tests[t].cfg_mask;
    end
    kind = predict_kind(t);
    if (kind != tests[t].exp_kind || predict_mask(t, kind) != tests[t].exp_mask) begin
      note_failure(t, $sformatf("table row %s disagrees with the forwarding rules",
                                tests[t].name));
    end
    for (int i = 0; i < tests[t].nwords; i++) begin
      word = {lcg_next(), lcg_next()};
      // Destination MAC only in the first word
      if (i == 0) word[`IGR_DMAC_MSB:`IGR_DMAC_LSB] = tests[t].dmac;
      in_valid = 1'b1;
      in_sop   = (i == 0);
      in_eop   = (i == tests[t].nwords - 1);
      in_port  = tests[t].port;
      in_data  = word;
      word_q.push_back('{t, exp_ptr, word, (i == tests[t].nwords - 1), cyc});
      exp_ptr = exp_ptr + 1'b1;
      @(negedge ingress_clock);
      cfg_wr = 1'b0;
    end
    tag_q.push_back('{t, tests[t].exp_kind, tests[t].exp_mask, tests[t].port,
                      `IGR_LEN_W'(tests[t].nwords), first_ptr});
  endtask

  // =========================================================================
  // Output monitor sampling on the falling edge where outputs are settled
  // =========================================================================
  always @(negedge ingress_clock) begin : monitor
    word_exp_t w;
    tag_exp_t  g;
    logic      eop_here;
    int        eop_test;
    eop_here = 1'b0;
    eop_test = -1;
    if (rst_n && buf_wr_valid === 1'b1) begin
      if (word_q.size() == 0) begin
        note_failure(-1, "buffer write seen with no word outstanding");
      end else begin
        w = word_q.pop_front();
        check_field(w.test, "ptr", w.ptr, buf_wr_ptr);
        check_data(w.test, w.data, buf_wr_data);
        check_field(w.test, "latency", 8'(PIPE_LAT), 8'(cyc - w.drive_cyc));
        eop_here = w.eop;
        eop_test = w.test;
      end
    end
    if (rst_n && tag_valid === 1'b1) begin
      if (tag_q.size() == 0) begin
        note_failure(-1, "tag seen with no frame outstanding");
      end else begin
        g = tag_q.pop_front();
        if (!eop_here || eop_test != g.test) begin
          note_failure(g.test, $sformatf("tag of %s not issued with its eop write",
                                         tests[g.test].name));
        end
        check_kind(g.test, g.kind, tag_kind);
        check_mask(g.test, g.mask, tag_dst_mask);
        check_field(g.test, "src_port", 8'(g.src_port), 8'(tag_src_port));
        check_field(g.test, "len", g.len, tag_len);
        check_field(g.test, "tag_ptr", g.ptr, tag_ptr);
        $display("test %-14s done, %0d errors", tests[g.test].name, test_err[g.test]);
        tags_seen++;
      end
    end
  end

  // =========================================================================
  // Main sequence and watchdog
  // =========================================================================
  initial begin
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_sop    = 1'b0;
    in_eop    = 1'b0;
    in_port   = '0;
    in_data   = '0;
    cfg_wr    = 1'b0;
    cfg_op    = CFG_SET;
    cfg_addr  = '0;
    cfg_mask  = '0;
    exp_ptr   = '0;
    lcg_state = 32'd43917;
    for (int i = 0; i < `IGR_FWD_DEPTH; i++) begin
      model_valid[i] = 1'b0;
      model_mask[i]  = '0;
    end
    load_tests();
    repeat (3) @(posedge ingress_clock);
    @(negedge ingress_clock);
    rst_n = 1'b1;
    // Frames back to back with no idle cycles
    for (int t = 0; t < NUM_TESTS; t++) drive_frame(t);
    in_valid = 1'b0;
    in_sop   = 1'b0;
    in_eop   = 1'b0;
    wait (tags_seen == NUM_TESTS);
    repeat (PIPE_LAT + 2) @(negedge ingress_clock);
    if (word_q.size() != 0) note_failure(-1, "buffer writes missing at end of run");
    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Limit from total words in the table
  initial begin : watchdog
    int limit;
    #1;
    limit = 3 + PIPE_LAT + MARGIN;
    for (int t = 0; t < NUM_TESTS; t++) limit += tests[t].nwords;
    repeat (limit) @(posedge ingress_clock);
    if (tag_q.size() != 0) begin
      $display("ERROR: timeout, no tag arrived for %s", tests[tag_q[0].test].name);
    end else begin
      $display("ERROR: timeout, run did not finish in %0d cycles", limit);
    end
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* hw/igr_decode/igr_decode.sv */
// Ingress decode stage registering input words and classifying each frame
`timescale 1ns/100ps
`include "igr_defines.svh"

module igr_decode import igr_frame_pkg::*; (
  input  logic                   ingress_clock,
  input  logic                   rst_n,
  // Shared segment stream
  input  logic                   in_valid,
  input  logic                   in_sop,
  input  logic                   in_eop,
  input  logic [`IGR_PORT_W-1:0] in_port,
  input  logic [`IGR_DATA_W-1:0] in_data,
  // Toward execute
  igr_seg_if.decode_mp           seg
);

  // Destination MAC of the current word, only meaningful on sop
  logic [`IGR_DMAC_MSB-`IGR_DMAC_LSB:0] dmac;
  // Kind that the word would give if it opened a frame
  frame_kind_e                          sop_kind;
  // Set between sop and eop of a multi-word frame
  logic                                 in_frame;

  // =======================================================================
  // Classification
  // =======================================================================
  assign dmac = in_data[`IGR_DMAC_MSB:`IGR_DMAC_LSB];

  // Runt wins over address type
  always_comb begin
    if (in_eop) begin
      sop_kind = KIND_RUNT;
    end else if (&dmac) begin
      // All ones, broadcast also has the group bit so test it first
      sop_kind = KIND_BCAST;
    end else if (in_data[`IGR_DMAC_GROUP]) begin
      sop_kind = KIND_MCAST;
    end else begin
      sop_kind = KIND_UCAST;
    end
  end

  // =======================================================================
  // Stage register
  // =======================================================================
  // Strobes, held kind and frame tracking
  always_ff @(posedge ingress_clock or negedge rst_n) begin
    if (!rst_n) begin
      seg.valid <= 1'b0;
      seg.sop   <= 1'b0;
      seg.eop   <= 1'b0;
      seg.kind  <= KIND_UCAST;
      in_frame  <= 1'b0;
    end else begin
      seg.valid <= in_valid;
      // Qualified so idle cycles never show stray markers
      seg.sop   <= in_valid & in_sop;
      seg.eop   <= in_valid & in_eop;
      // Kind latched on sop, rides along on every later word
      if (in_valid && in_sop) begin
        seg.kind <= sop_kind;
      end
      if (in_valid) begin
        if (in_eop) begin
          in_frame <= 1'b0;
        end else if (in_sop) begin
          in_frame <= 1'b1;
        end
      end
    end
  end

  // Word payload
  always_ff @(posedge ingress_clock) begin
    if (in_valid) begin
      seg.port <= in_port;
      seg.data <= in_data;
    end
  end

  // =======================================================================
  // Checks
  // =======================================================================
  // Frames never interleave on the shared stream
  a_no_nested_sop: assert property (
    @(posedge ingress_clock) disable iff (!rst_n)
    in_valid && in_sop |-> !in_frame
  );

  // Eop only closes a frame that a previous sop opened
  a_no_stray_eop: assert property (
    @(posedge ingress_clock) disable iff (!rst_n)
    in_valid && in_eop && !in_sop |-> in_frame
  );

endmodule

/* hw/igr_execute/igr_execute.sv */
// Ingress execute stage resolving the destination mask and counting frame words
`timescale 1ns/100ps
`include "igr_defines.svh"

module igr_execute import igr_frame_pkg::*, igr_fwd_pkg::*; (
  input  logic                      ingress_clock,
  input  logic                      rst_n,
  // Table configuration, applied on the strobed edge
  input  logic                      cfg_wr,
  input  cfg_op_e                   cfg_op,
  input  logic [`IGR_FWD_AW-1:0]    cfg_addr,
  input  logic [`IGR_NUM_PORTS-1:0] cfg_mask,
  // From decode
  igr_seg_if.exec_mp                seg_in,
  // Toward result
  igr_seg_if.exec_drv_mp            seg_out,
  // Words so far, equals frame length on the eop word
  output logic [`IGR_LEN_W-1:0]     frame_len
);

  // Forwarding table
  fwd_entry_t                fwd_tbl [`IGR_FWD_DEPTH];
  // Entry addressed by the current word
  fwd_entry_t                hit_entry;
  // One-hot of the source port
  logic [`IGR_NUM_PORTS-1:0] src_bit;
  // Mask before and after source removal
  logic [`IGR_NUM_PORTS-1:0] raw_mask;
  logic [`IGR_NUM_PORTS-1:0] sop_mask;

  // =======================================================================
  // Forwarding table
  // =======================================================================
  // Empty after reset, every lookup misses until configured
  always_ff @(posedge ingress_clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `IGR_FWD_DEPTH; i++) begin
        fwd_tbl[i] <= '0;
      end
    end else if (cfg_wr) begin
      case (cfg_op)
        CFG_SET: begin
          fwd_tbl[cfg_addr] <= '{valid: 1'b1, port_mask: cfg_mask};
        end
        default: begin
          fwd_tbl[cfg_addr] <= '0;
        end
      endcase
    end
  end

  // =======================================================================
  // Mask resolution
  // =======================================================================
  // Index from low MAC bits, a write on this same edge is not seen
  assign hit_entry = fwd_tbl[seg_in.data[`IGR_DMAC_LSB +: `IGR_FWD_AW]];
  assign src_bit   = `IGR_NUM_PORTS'(1) << seg_in.port;

  always_comb begin
    case (seg_in.kind)
      // Dropped frame goes nowhere
      KIND_RUNT: begin
        raw_mask = '0;
      end
      // Miss floods like a group address
      KIND_UCAST: begin
        raw_mask = hit_entry.valid ? hit_entry.port_mask : '1;
      end
      default: begin
        raw_mask = '1;
      end
    endcase
    // Never reflect a frame back to its own port
    sop_mask = raw_mask & ~src_bit;
  end

  // =======================================================================
  // Stage register
  // =======================================================================
  always_ff @(posedge ingress_clock or negedge rst_n) begin
    if (!rst_n) begin
      seg_out.valid    <= 1'b0;
      seg_out.sop      <= 1'b0;
      seg_out.eop      <= 1'b0;
      seg_out.kind     <= KIND_UCAST;
      seg_out.dst_mask <= '0;
      frame_len        <= '0;
    end else begin
      seg_out.valid <= seg_in.valid;
      seg_out.sop   <= seg_in.sop;
      seg_out.eop   <= seg_in.eop;
      if (seg_in.valid) begin
        seg_out.kind <= seg_in.kind;
        // Mask and count restart on sop, mask held to eop
        if (seg_in.sop) begin
          seg_out.dst_mask <= sop_mask;
          frame_len        <= `IGR_LEN_W'(1);
        end else begin
          frame_len <= frame_len + 1'b1;
        end
      end
    end
  end

  // Word payload
  always_ff @(posedge ingress_clock) begin
    if (seg_in.valid) begin
      seg_out.port <= seg_in.port;
      seg_out.data <= seg_in.data;
    end
  end

  // =======================================================================
  // Checks
  // =======================================================================
  // Mask held from sop must exclude the port of every later word
  a_no_src_in_mask: assert property (
    @(posedge ingress_clock) disable iff (!rst_n)
    seg_out.valid |-> ((`IGR_NUM_PORTS'(1) << seg_out.port) & seg_out.dst_mask) == '0
  );

endmodule

/* hw/igr_result/igr_result.sv */
// Ingress result stage assigning buffer pointers and emitting end-of-frame tags
`timescale 1ns/100ps
`include "igr_defines.svh"

module igr_result import igr_frame_pkg::*; (
  input  logic                      ingress_clock,
  input  logic                      rst_n,
  // From execute
  igr_seg_if.result_mp              seg,
  input  logic [`IGR_LEN_W-1:0]     frame_len,
  // Packet buffer writes, one per word
  output logic                      buf_wr_valid,
  output logic [`IGR_PTR_W-1:0]     buf_wr_ptr,
  output logic [`IGR_DATA_W-1:0]    buf_wr_data,
  // Tag, pulses with the eop word write
  output logic                      tag_valid,
  output frame_kind_e               tag_kind,
  output logic [`IGR_NUM_PORTS-1:0] tag_dst_mask,
  output logic [`IGR_PORT_W-1:0]    tag_src_port,
  output logic [`IGR_LEN_W-1:0]     tag_len,
  output logic [`IGR_PTR_W-1:0]     tag_ptr
);

  // Next free segment, wraps with no free list
  logic [`IGR_PTR_W-1:0] wr_ptr;
  // Pointer given to the sop word of the open frame
  logic [`IGR_PTR_W-1:0] first_ptr;
  igr_tag_t              tag_q;

  // =======================================================================
  // Pointer and strobes
  // =======================================================================
  always_ff @(posedge ingress_clock or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr       <= '0;
      buf_wr_valid <= 1'b0;
      tag_valid    <= 1'b0;
    end else begin
      buf_wr_valid <= seg.valid;
      tag_valid    <= seg.valid & seg.eop;
      if (seg.valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  // =======================================================================
  // Buffer write and tag capture
  // =======================================================================
  always_ff @(posedge ingress_clock) begin
    if (seg.valid) begin
      buf_wr_ptr  <= wr_ptr;
      buf_wr_data <= seg.data;
      if (seg.sop) begin
        first_ptr <= wr_ptr;
      end
      if (seg.eop) begin
        tag_q.kind     <= seg.kind;
        tag_q.dst_mask <= seg.dst_mask;
        tag_q.src_port <= seg.port;
        tag_q.len      <= frame_len;
        // Single-word frame has not latched first_ptr yet
        tag_q.ptr      <= seg.sop ? wr_ptr : first_ptr;
      end
    end
  end

  // Tag fields out as plain ports
  assign tag_kind     = tag_q.kind;
  assign tag_dst_mask = tag_q.dst_mask;
  assign tag_src_port = tag_q.src_port;
  assign tag_len      = tag_q.len;
  assign tag_ptr      = tag_q.ptr;

  // =======================================================================
  // Checks
  // =======================================================================
  // Execute count must have seen at least the eop word
  a_tag_len_nonzero: assert property (
    @(posedge ingress_clock) disable iff (!rst_n)
    tag_valid |-> tag_len != '0
  );

endmodule

/* hw/igr_top.sv */
// Ingress block top joining decode, execute and result into a three-stage pipeline
`timescale 1ns/100ps
`include "igr_defines.svh"

module igr_top import igr_frame_pkg::*, igr_fwd_pkg::*; (
  input  logic                      ingress_clock,
  input  logic                      rst_n,
  // Segment input
  input  logic                      in_valid,
  input  logic                      in_sop,
  input  logic                      in_eop,
  input  logic [`IGR_PORT_W-1:0]    in_port,
  input  logic [`IGR_DATA_W-1:0]    in_data,
  // Configuration
  input  logic                      cfg_wr,
  input  cfg_op_e                   cfg_op,
  input  logic [`IGR_FWD_AW-1:0]    cfg_addr,
  input  logic [`IGR_NUM_PORTS-1:0] cfg_mask,
  // Buffer writes
  output logic                      buf_wr_valid,
  output logic [`IGR_PTR_W-1:0]     buf_wr_ptr,
  output logic [`IGR_DATA_W-1:0]    buf_wr_data,
  // Tags
  output logic                      tag_valid,
  output frame_kind_e               tag_kind,
  output logic [`IGR_NUM_PORTS-1:0] tag_dst_mask,
  output logic [`IGR_PORT_W-1:0]    tag_src_port,
  output logic [`IGR_LEN_W-1:0]     tag_len,
  output logic [`IGR_PTR_W-1:0]     tag_ptr
);

  // Frame length from execute, aligned with exe_seg
  logic [`IGR_LEN_W-1:0] frame_len;

  // =======================================================================
  // Stage buses
  // =======================================================================
  igr_seg_if dec_seg ();
  igr_seg_if exe_seg ();

  // =======================================================================
  // Pipeline
  // =======================================================================
  igr_decode u_decode (
    .ingress_clock (ingress_clock),
    .rst_n         (rst_n),
    .in_valid      (in_valid),
    .in_sop        (in_sop),
    .in_eop        (in_eop),
    .in_port       (in_port),
    .in_data       (in_data),
    .seg           (dec_seg)
  );

  igr_execute u_execute (
    .ingress_clock (ingress_clock),
    .rst_n         (rst_n),
    .cfg_wr        (cfg_wr),
    .cfg_op        (cfg_op),
    .cfg_addr      (cfg_addr),
    .cfg_mask      (cfg_mask),
    .seg_in        (dec_seg),
    .seg_out       (exe_seg),
    .frame_len     (frame_len)
  );

  igr_result u_result (
    .ingress_clock (ingress_clock),
    .rst_n         (rst_n),
    .seg           (exe_seg),
    .frame_len     (frame_len),
    .buf_wr_valid  (buf_wr_valid),
    .buf_wr_ptr    (buf_wr_ptr),
    .buf_wr_data   (buf_wr_data),
    .tag_valid     (tag_valid),
    .tag_kind      (tag_kind),
    .tag_dst_mask  (tag_dst_mask),
    .tag_src_port  (tag_src_port),
    .tag_len       (tag_len),
    .tag_ptr       (tag_ptr)
  );

endmodule

/* list.f */
+incdir+common
common/igr_frame_pkg.sv
common/igr_fwd_pkg.sv
common/igr_seg_if.sv
hw/igr_decode/igr_decode.sv
hw/igr_execute/igr_execute.sv
hw/igr_result/igr_result.sv
hw/igr_top.sv
dv/igr_tb.sv
